// ==== logic/buf_geom_pkg.sv ====
// buffer geometry
// pixel and bus word widths, plus the data types built on them

package buf_geom_pkg;

  // one pixel, 16 bits
  localparam int PIX_W  = 16;
  // wishbone data width
  localparam int WORD_W = 64;
  // pixels carried by one bus word
  localparam int LANES  = WORD_W / PIX_W;

  ////////////////////
  // data types
  ////////////////////

  typedef logic [PIX_W-1:0]    pix_t;
  typedef logic [WORD_W-1:0]   word_t;

  // byte select of a full bus word
  typedef logic [WORD_W/8-1:0] be_t;
  // byte enable of a single pixel lane
  typedef logic [PIX_W/8-1:0]  pix_be_t;

endpackage

// ==== logic/buf_bus_pkg.sv ====
// bus and port bundles of the line buffer
// wishbone request/response, bank write, pixel read and the FSM states

package buf_bus_pkg;

  ////////////////////
  // wishbone classic
  ////////////////////

  // master to slave, held until ack or err
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [15:0]         adr;
    buf_geom_pkg::be_t   sel;
    buf_geom_pkg::word_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    logic                err;
    buf_geom_pkg::word_t dat;
  } wb_rsp_t;

  ////////////////////
  // internal ports
  ////////////////////

  // one word write into the bank array, word address
  typedef struct packed {
    logic                en;
    logic [15:0]         adr;
    buf_geom_pkg::be_t   be;
    buf_geom_pkg::word_t dat;
  } bank_wr_t;

  // one pixel read lane, pixel address
  typedef struct packed {
    logic        req;
    logic [15:0] adr;
  } pix_rd_t;

  typedef enum logic {WB_IDLE, WB_RESP} wb_state_e;

  typedef enum logic [1:0] {SC_IDLE, SC_RUN, SC_LAST} scan_state_e;

endpackage

// ==== logic/pix_bank.sv ====
// single pixel bank
// simple dual-port ram, byte-lane write port, registered read port

`timescale 1ns/1ps

module pix_bank #(
  parameter int BANK_DEPTH = 512
) (
  input  logic                      clk_b_i,
  input  buf_geom_pkg::pix_be_t     we_i,
  input  logic [$clog2(BANK_DEPTH)-1:0] waddr_i,
  input  buf_geom_pkg::pix_t        wdata_i,
  input  logic                      re_i,
  input  logic [$clog2(BANK_DEPTH)-1:0] raddr_i,
  output buf_geom_pkg::pix_t        rdata_o
);

  // storage array, inferred
  buf_geom_pkg::pix_t mem [BANK_DEPTH];

  // write side, one enable per byte
  always_ff @(posedge clk_b_i) begin
    for (int k = 0; k < $bits(buf_geom_pkg::pix_be_t); k++) begin
      if (we_i[k]) begin
        mem[waddr_i][8*k +: 8] <= wdata_i[8*k +: 8];
      end
    end
  end

  // read side, output holds while idle
  // same-cycle collision returns the old word
  always_ff @(posedge clk_b_i) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// ==== logic/bank_array.sv ====
// banked pixel memory
// bus words are split over one half of the banks, NPX read lanes
// go through a crossbar steered by the delayed bank index

`timescale 1ns/1ps

module bank_array #(
  parameter int NB_BANKS   = 8,
  parameter int BANK_DEPTH = 512,
  parameter int NPX        = 4
) (
  input  logic                              clk_b_i,
  input  logic                              rst_ni,
  input  buf_bus_pkg::bank_wr_t             wr_i,
  input  buf_bus_pkg::pix_rd_t  [NPX-1:0]   rd_i,
  output buf_geom_pkg::pix_t    [NPX-1:0]   pix_o
);

  // bank index bits, row bits, banks per half
  localparam int BW   = $clog2(NB_BANKS);
  localparam int RW   = $clog2(BANK_DEPTH);
  localparam int HALF = NB_BANKS / 2;
  localparam int PW   = buf_geom_pkg::PIX_W;
  localparam int PBE  = PW / 8;

  buf_geom_pkg::pix_t [NB_BANKS-1:0] bank_rdata;
  // bank index per lane, now and one cycle later
  logic [NPX-1:0][BW-1:0]            idx_d;
  logic [NPX-1:0][BW-1:0]            idx_q;

  // one bus word must fill exactly one half
  if (NB_BANKS != 2 * buf_geom_pkg::LANES) begin : g_geom_chk
    $error("bank_array: NB_BANKS must be twice the word lanes");
  end

  ////////////////////
  // banks
  ////////////////////

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    // word lane and half served by this bank
    localparam int   LANE = b % HALF;
    localparam logic HI   = (b >= HALF);

    buf_geom_pkg::pix_be_t wbe;
    logic                  re;
    logic [RW-1:0]         raddr;

    // even words land low, odd words high
    assign wbe = (wr_i.en && (wr_i.adr[0] == HI)) ? wr_i.be[LANE*PBE +: PBE] : '0;

    // find the lane that points here, at most one does
    always_comb begin
      re    = 1'b0;
      raddr = '0;
      for (int j = 0; j < NPX; j++) begin
        if (rd_i[j].req && (rd_i[j].adr[BW-1:0] == BW'(b))) begin
          re    = 1'b1;
          raddr = rd_i[j].adr[BW +: RW];
        end
      end
    end

    pix_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .clk_b_i (clk_b_i),
      .we_i    (wbe),
      .waddr_i (wr_i.adr[1 +: RW]),
      .wdata_i (wr_i.dat[LANE*PW +: PW]),
      .re_i    (re),
      .raddr_i (raddr),
      .rdata_o (bank_rdata[b])
    );
  end

  ////////////////////
  // read crossbar
  ////////////////////

  for (genvar j = 0; j < NPX; j++) begin : g_lane
    assign idx_d[j] = rd_i[j].adr[BW-1:0];
    // bank output comes back one cycle later
    assign pix_o[j] = bank_rdata[idx_q[j]];
  end

  // index delay matches the ram latency
  always_ff @(posedge clk_b_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= idx_d;
    end
  end

  // aligned groups never put two lanes on one bank
  for (genvar a = 0; a < NPX; a++) begin : g_chk_a
    for (genvar c = a + 1; c < NPX; c++) begin : g_chk_c
      a_no_bank_clash : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
        !(rd_i[a].req && rd_i[c].req && (idx_d[a] == idx_d[c])));
    end
  end

endmodule

// ==== logic/wb_write_port.sv ====
// wishbone classic write slave
// one wait state per cycle, writes go to the banks, reads get err

`timescale 1ns/1ps

module wb_write_port (
  input  logic                  clk_b_i,
  input  logic                  rst_ni,
  input  buf_bus_pkg::wb_req_t  wb_i,
  output buf_bus_pkg::wb_rsp_t  wb_o,
  output buf_bus_pkg::bank_wr_t wr_o
);

  buf_bus_pkg::wb_state_e state_q;
  buf_bus_pkg::wb_state_e state_d;
  logic                   take;
  logic                   resp;
  logic                   we_q;
  // captured request payload
  logic [15:0]            adr_q;
  buf_geom_pkg::be_t      sel_q;
  buf_geom_pkg::word_t    dat_q;

  assign take = (state_q == buf_bus_pkg::WB_IDLE) && wb_i.cyc && wb_i.stb;
  assign resp = (state_q == buf_bus_pkg::WB_RESP);

  // idle -> resp on a new cycle, resp lasts exactly one clock
  always_comb begin
    state_d = state_q;
    if (take) begin
      state_d = buf_bus_pkg::WB_RESP;
    end else if (resp) begin
      state_d = buf_bus_pkg::WB_IDLE;
    end
  end

  always_ff @(posedge clk_b_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= buf_bus_pkg::WB_IDLE;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take) begin
        we_q <= wb_i.we;
      end
    end
  end

  always_ff @(posedge clk_b_i) begin
    if (take) begin
      adr_q <= wb_i.adr;
      sel_q <= wb_i.sel;
      dat_q <= wb_i.dat;
    end
  end

  // ack and bank write share the wait-state cycle
  always_comb begin
    wb_o.ack = resp && we_q;
    wb_o.err = resp && !we_q;
    // no read path, data bus stays quiet
    wb_o.dat = '0;
    wr_o.en  = resp && we_q;
    wr_o.adr = adr_q;
    wr_o.be  = sel_q;
    wr_o.dat = dat_q;
  end

  // one response, only inside a live cycle, never both kinds
  a_wb_rsp_legal : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
    (wb_o.ack || wb_o.err) |-> (wb_i.cyc && wb_i.stb && !(wb_o.ack && wb_o.err)));

endmodule

// ==== logic/scan_ctrl.sv ====
// scan sequencer
// accepts start while idle, steps the counter, flags done after the last read

`timescale 1ns/1ps

module scan_ctrl (
  input  logic clk_b_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic last_i,
  output logic load_o,
  output logic step_o,
  output logic busy_o,
  output logic done_o
);

  buf_bus_pkg::scan_state_e state_q;
  buf_bus_pkg::scan_state_e state_d;

  // start only counts while idle
  assign load_o = start_i && (state_q == buf_bus_pkg::SC_IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      buf_bus_pkg::SC_IDLE: if (load_o) state_d = buf_bus_pkg::SC_RUN;
      // last group issued, wait for its data
      buf_bus_pkg::SC_RUN:  if (last_i) state_d = buf_bus_pkg::SC_LAST;
      buf_bus_pkg::SC_LAST: state_d = buf_bus_pkg::SC_IDLE;
      default:              state_d = buf_bus_pkg::SC_IDLE;
    endcase
  end

  always_ff @(posedge clk_b_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= buf_bus_pkg::SC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // one read group per running cycle
  assign step_o = (state_q == buf_bus_pkg::SC_RUN);
  assign busy_o = (state_q != buf_bus_pkg::SC_IDLE);
  // lines up with the last valid group
  assign done_o = (state_q == buf_bus_pkg::SC_LAST);

  // counter drained outside a run, last only seen while stepping
  a_last_in_run : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
    last_i |-> (state_q == buf_bus_pkg::SC_RUN));

endmodule

// ==== logic/scan_counter.sv ====
// scan address generator
// walks NPX pixel addresses per group, counts the groups left

`timescale 1ns/1ps

module scan_counter #(
  parameter int NPX = 4
) (
  input  logic                            clk_b_i,
  input  logic                            rst_ni,
  input  logic                            load_i,
  input  logic                            step_i,
  input  logic [15:0]                     base_i,
  input  logic [15:0]                     len_i,
  output buf_bus_pkg::pix_rd_t [NPX-1:0]  rd_o,
  output logic                            last_o
);

  // group start address and groups remaining
  logic [15:0] addr_q;
  logic [15:0] rem_q;

  always_ff @(posedge clk_b_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rem_q  <= '0;
    end else if (load_i) begin
      addr_q <= base_i;
      rem_q  <= len_i;
    end else if (step_i) begin
      addr_q <= addr_q + 16'(NPX);
      rem_q  <= rem_q - 16'd1;
    end
  end

  // consecutive pixels, one per lane
  for (genvar j = 0; j < NPX; j++) begin : g_lane
    assign rd_o[j].req = step_i;
    assign rd_o[j].adr = addr_q + 16'(j);
  end

  assign last_o = (rem_q == 16'd1);

  // zero groups would never raise last
  a_len_nonzero : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
    load_i |-> (len_i != '0));

endmodule

// ==== logic/line_buffer_top.sv ====
// pixel line buffer top
// wishbone writes in, fixed-rate groups of NPX pixels out

`timescale 1ns/1ps

module line_buffer_top #(
  parameter int NB_BANKS   = 8,
  parameter int BANK_DEPTH = 512,
  parameter int NPX        = 4
) (
  input  logic                             clk_b_i,
  input  logic                             rst_ni,
  input  buf_bus_pkg::wb_req_t             wb_i,
  output buf_bus_pkg::wb_rsp_t             wb_o,
  input  logic                             start_i,
  input  logic [15:0]                      base_i,
  input  logic [15:0]                      len_i,
  output logic                             busy_o,
  output logic                             done_o,
  output logic                             pix_valid_o,
  output buf_geom_pkg::pix_t [NPX-1:0]     pix_o
);

  buf_bus_pkg::bank_wr_t            wr;
  buf_bus_pkg::pix_rd_t [NPX-1:0]   rd;
  logic                             load;
  logic                             step;
  logic                             last;

  wb_write_port u_wb (
    .clk_b_i (clk_b_i), .rst_ni (rst_ni), .wb_i (wb_i), .wb_o (wb_o), .wr_o (wr)
  );

  scan_ctrl u_ctrl (
    .clk_b_i (clk_b_i), .rst_ni (rst_ni), .start_i (start_i), .last_i (last),
    .load_o (load), .step_o (step), .busy_o (busy_o), .done_o (done_o)
  );

  scan_counter #(.NPX (NPX)) u_cnt (
    .clk_b_i (clk_b_i), .rst_ni (rst_ni), .load_i (load), .step_i (step),
    .base_i (base_i), .len_i (len_i), .rd_o (rd), .last_o (last)
  );

  bank_array #(.NB_BANKS (NB_BANKS), .BANK_DEPTH (BANK_DEPTH), .NPX (NPX)) u_mem (
    .clk_b_i (clk_b_i), .rst_ni (rst_ni), .wr_i (wr), .rd_i (rd), .pix_o (pix_o)
  );

  // valid trails the step by the ram latency
  always_ff @(posedge clk_b_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= step;
    end
  end

endmodule

// ==== sim/tb_line_buffer.sv ====
// line buffer testbench
// wishbone fills a word model, scans are checked lane by lane against it

`timescale 1ns/1ps

module tb_line_buffer;

  localparam int NB_BANKS   = 8;
  localparam int BANK_DEPTH = 512;
  localparam int NPX        = 4;
  localparam int CLK_PERIOD = 40;
  localparam int LANES      = buf_geom_pkg::LANES;
  localparam int PW         = buf_geom_pkg::PIX_W;
  localparam int PIXELS     = NB_BANKS * BANK_DEPTH;
  localparam int WORDS      = PIXELS / LANES;
  localparam int AW         = $clog2(WORDS);
  localparam int GW         = $clog2(PIXELS / NPX);
  // test sizes
  localparam int N_SEL      = 200;
  localparam int N_RD       = 8;
  localparam int N_SCANS    = 20;
  localparam int MAX_LEN    = 40;
  localparam int POKE_LEN   = 30;
  // bus writes plus scan groups, 4 cycles each, plus margin
  localparam int WD_CYCLES  = 4 * (WORDS + N_SEL + N_RD + 2 * (PIXELS / NPX)
                              + N_SCANS * MAX_LEN + 2 * POKE_LEN) + 500;

  logic                         clk_b;
  logic                         rst_n;
  buf_bus_pkg::wb_req_t         wb_req;
  buf_bus_pkg::wb_rsp_t         wb_rsp;
  logic                         start;
  logic [15:0]                  base;
  logic [15:0]                  len;
  logic                         busy;
  logic                         done;
  logic                         pix_valid;
  buf_geom_pkg::pix_t [NPX-1:0] pix;

  // word model, as the bus master sees the buffer
  buf_geom_pkg::word_t model [WORDS];
  logic [15:0]         lfsr;
  string               test_name;
  // scan being checked, owned by the compare process
  int                  exp_base  = 0;
  int                  exp_len   = 0;
  int                  grp_cnt   = 0;
  logic                done_seen = 1'b0;
  // a scan runs from its accepted start up to its done group
  logic                scan_on   = 1'b0;

  line_buffer_top #(
    .NB_BANKS   (NB_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .NPX        (NPX)
  ) dut (
    .clk_b_i     (clk_b),
    .rst_ni      (rst_n),
    .wb_i        (wb_req),
    .wb_o        (wb_rsp),
    .start_i     (start),
    .base_i      (base),
    .len_i       (len),
    .busy_o      (busy),
    .done_o      (done),
    .pix_valid_o (pix_valid),
    .pix_o       (pix)
  );

  initial clk_b = 1'b0;
  always #(CLK_PERIOD / 2) clk_b = ~clk_b;

  ////////////////////
  // helpers
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  // pixel p sits in bank p mod 8, row p/8
  // banks 0-3 hold even words, banks 4-7 odd words
  function automatic buf_geom_pkg::pix_t ref_pix(input int p);
    int bank;
    int w;
    bank = p % NB_BANKS;
    w    = 2 * (p / NB_BANKS) + bank / LANES;
    return model[w][PW * (bank % LANES) +: PW];
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    stop_run();
  endtask

  task automatic check_pix(input buf_geom_pkg::pix_t exp, input buf_geom_pkg::pix_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rsp(input buf_bus_pkg::wb_rsp_t exp, input buf_bus_pkg::wb_rsp_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////
  // bus driver
  ////////////////////

  // one classic cycle, held until ack or err
  task automatic wb_cycle(input logic we, input logic [15:0] adr,
                          input buf_geom_pkg::be_t sel, input buf_geom_pkg::word_t dat);
    buf_bus_pkg::wb_rsp_t exp;
    int                   waits;
    exp.ack = we;
    exp.err = !we;
    exp.dat = '0;
    wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
    waits   = 0;
    do begin
      @(posedge clk_b);
      #1;
      waits++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waits < 8);
    if (waits != 1) begin
      abort_run($sformatf("bus response after %0d cycles instead of one", waits));
    end
    check_rsp(exp, wb_rsp);
    @(posedge clk_b);
    #1;
    // only one response per cycle
    if (wb_rsp.ack || wb_rsp.err) begin
      abort_run("second bus response in the same cycle");
    end
    #1;
    wb_req = '0;
  endtask

  // merge selected bytes into the model, then write
  task automatic write_word(input int w, input buf_geom_pkg::be_t sel,
                            input buf_geom_pkg::word_t dat);
    for (int i = 0; i < $bits(buf_geom_pkg::be_t); i++) begin
      if (sel[i]) begin
        model[w][8*i +: 8] = dat[8*i +: 8];
      end
    end
    wb_cycle(1'b1, 16'(w), sel, dat);
  endtask

  ////////////////////
  // scan driver and compare
  ////////////////////

  // poke > 0 raises a second start that many cycles in
  task automatic run_scan(input int b, input int l, input int poke);
    int cyc;
    start = 1'b1;
    base  = 16'(b);
    len   = 16'(l);
    cyc   = 0;
    do begin
      @(posedge clk_b);
      #2;
      cyc++;
      start = (cyc == poke);
      base  = start ? 16'((b + 64 * NPX) % PIXELS) : 16'(b);
      len   = start ? 16'd3 : 16'(l);
    end while (!done_seen && cyc < l + 8);
    start = 1'b0;
    if (!done_seen) abort_run("scan never raised done");
    if (busy) abort_run("busy still high after done");
    if (grp_cnt != l) begin
      abort_run($sformatf("%0d valid groups instead of %0d", grp_cnt, l));
    end
  endtask

  // mid-cycle sampling, outputs are settled
  always @(negedge clk_b) begin
    if (rst_n) begin
      if (busy !== scan_on) abort_run("busy does not match the running scan");
      // a start is taken only while no scan runs
      if (start && !scan_on) begin
        exp_base  = int'(base);
        exp_len   = int'(len);
        grp_cnt   = 0;
        done_seen = 1'b0;
        scan_on   = 1'b1;
      end
      if (done && !pix_valid) abort_run("done without a valid group");
      if (pix_valid) begin
        if (grp_cnt >= exp_len) abort_run("extra pixel group after the scan");
        for (int j = 0; j < NPX; j++) begin
          check_pix(ref_pix(exp_base + grp_cnt * NPX + j), pix[j]);
        end
        if (done != (grp_cnt == exp_len - 1)) abort_run("done not on the last group");
        if (done) begin
          done_seen = 1'b1;
          scan_on   = 1'b0;
        end
        grp_cnt++;
      end
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired, run did not finish in time");
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int b;
    int l;
    int room;
    rst_n     = 1'b0;
    wb_req    = '0;
    start     = 1'b0;
    base      = '0;
    len       = '0;
    lfsr      = 16'd55511;
    test_name = "reset";
    repeat (10) @(posedge clk_b);
    #2;
    if (busy || done || pix_valid || wb_rsp.ack || wb_rsp.err) begin
      abort_run("outputs not idle in reset");
    end
    rst_n = 1'b1;

    // every word, all bytes
    test_name = "full_fill";
    for (int w = 0; w < WORDS; w++) begin
      write_word(w, '1, rand_bits(64));
    end
    run_scan(0, PIXELS / NPX, 0);

    test_name = "byte_select";
    for (int i = 0; i < N_SEL; i++) begin
      write_word(int'(rand_bits(AW)), buf_geom_pkg::be_t'(rand_bits(8)), rand_bits(64));
    end
    run_scan(0, PIXELS / NPX, 0);

    // aligned base, length kept inside the buffer
    test_name = "random_scan";
    for (int i = 0; i < N_SCANS; i++) begin
      b    = NPX * int'(rand_bits(GW));
      room = (PIXELS - b) / NPX;
      l    = 1 + int'(rand_bits(6)) % ((room < MAX_LEN) ? room : MAX_LEN);
      run_scan(b, l, 0);
    end

    test_name = "wb_read";
    for (int i = 0; i < N_RD; i++) begin
      wb_cycle(1'b0, 16'(rand_bits(AW)), '1, '0);
    end

    test_name = "start_busy";
    run_scan(64, POKE_LEN, 5);
    run_scan(PIXELS - POKE_LEN * NPX, POKE_LEN, POKE_LEN - 1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/buf_geom_pkg.sv
logic/buf_bus_pkg.sv
logic/pix_bank.sv
logic/bank_array.sv
logic/wb_write_port.sv
logic/scan_ctrl.sv
logic/scan_counter.sv
logic/line_buffer_top.sv
sim/tb_line_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the line buffer testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_line_buffer \
  --Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_line_buffer > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0
